//--- flist.f
+incdir+hw
hw/uram_word_pkg.sv
hw/uram_ctrl_pkg.sv
hw/uram_secded.sv
hw/uram_block.sv
hw/uram_port_arbiter.sv
hw/uram_scrubber.sv
hw/uram_subsystem_top.sv
sim/tb_uram_subsystem.sv

//--- hw/uram_block.sv
`default_nettype none
`include "uram_defines.svh"

module uram_block #(
	parameter bit ECC_A = 1'b1,
	parameter bit ECC_B = 1'b0
)(
	input wire								clk,
	input wire								rst_n,

	// Port A
	input wire								a_en,
	input wire								a_wr,
	input wire [`URAM_ADDR_W-1:0]			a_addr,
	input wire [`URAM_LANES-1:0]			a_bwe,
	input wire uram_word_pkg::uram_word_u	a_wdata,
	input wire								a_inject_seu,
	input wire								a_inject_deu,
	output uram_word_pkg::uram_word_u		a_rdata,
	output logic							a_rdaccess,
	output logic							a_seu,
	output logic							a_deu,

	// Port B
	input wire								b_en,
	input wire								b_wr,
	input wire [`URAM_ADDR_W-1:0]			b_addr,
	input wire [`URAM_LANES-1:0]			b_bwe,
	input wire uram_word_pkg::uram_word_u	b_wdata,
	input wire								b_inject_seu,
	input wire								b_inject_deu,
	output uram_word_pkg::uram_word_u		b_rdata,
	output logic							b_rdaccess,
	output logic							b_seu,
	output logic							b_deu
);
	import uram_word_pkg::*;
	import uram_ctrl_pkg::*;

	localparam int PORTS = 2;
	// Index 0 is port A, index 1 is port B
	localparam bit [PORTS-1:0] ECC_EN = {ECC_B, ECC_A};

	// All-zero words are valid codewords
	uram_word_u					mem [`URAM_DEPTH] = '{default: '0};

	// Both ports gathered for one shared generate body
	logic [PORTS-1:0]			en;
	logic [PORTS-1:0]			wr;
	logic [PORTS-1:0]			inj_seu;
	logic [PORTS-1:0]			inj_deu;
	logic [`URAM_ADDR_W-1:0]	addr [PORTS];
	logic [`URAM_LANES-1:0]		bwe [PORTS];
	uram_word_u					wdata [PORTS];
	uram_word_u					wword [PORTS];

	assign en = {b_en, a_en};
	assign wr = {b_wr, a_wr};
	assign inj_seu = {b_inject_seu, a_inject_seu};
	assign inj_deu = {b_inject_deu, a_inject_deu};
	assign addr = '{a_addr, b_addr};
	assign bwe = '{a_bwe, b_bwe};
	assign wdata = '{a_wdata, b_wdata};

	for (genvar p = 0; p < PORTS; p++) begin : g_port
		uram_word_u		stored;
		uram_word_u		merged;
		uram_word_u		read_word;
		uram_word_u		rdata_q;
		logic			rd;
		logic			seu_next;
		logic			deu_next;
		logic			rdaccess_q;
		logic			seu_q;
		logic			deu_q;

		assign stored = mem[addr[p]];
		assign rd = en[p] && !wr[p];

		if (ECC_EN[p]) begin : g_ecc
			logic [`URAM_CHECK_W-1:0]	check;
			logic [`URAM_DATA_W-1:0]	fixed;
			uram_ecc_status_e			status;

			uram_secded u_secded(
				.enc_data(wdata[p].ecc.data),
				.enc_check(check),
				.dec_word(stored),
				.dec_data(fixed),
				.dec_status(status)
			);

			// Full-word write with injected flips on the encoded data
			always_comb begin
				merged.ecc.check = check;
				merged.ecc.data = wdata[p].ecc.data ^
					{{(`URAM_DATA_W-2){1'b0}}, inj_deu[p], inj_seu[p] | inj_deu[p]};
			end

			always_comb begin
				read_word.ecc.check = stored.ecc.check;
				read_word.ecc.data = fixed;
			end
			assign seu_next = status == ECC_CORRECTED;
			assign deu_next = status == ECC_FATAL;

			// Clean words pass through the decoder untouched
			clean_read_chk: assert property (@(posedge clk) disable iff (!rst_n)
				status == ECC_CLEAN |-> fixed == stored.ecc.data);
		end else begin : g_raw
			// Lanes without enable keep their stored byte
			always_comb begin
				for (int l = 0; l < `URAM_LANES; l++)
					merged.lanes[l] = bwe[p][l] ? wdata[p].lanes[l] : stored.lanes[l];
			end
			assign read_word = stored;
			assign seu_next = 1'b0;
			assign deu_next = 1'b0;
		end

		assign wword[p] = merged;

		// Read data held until the next read
		always_ff @(posedge clk) begin
			if (rd)
				rdata_q <= read_word;
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				rdaccess_q <= 1'b0;
				seu_q <= 1'b0;
				deu_q <= 1'b0;
			end else begin
				rdaccess_q <= rd;
				seu_q <= rd && seu_next;
				deu_q <= rd && deu_next;
			end
		end

		// Requesters only inject on writes
		inject_on_read_chk: assert property (@(posedge clk) disable iff (!rst_n)
			rd |-> !(inj_seu[p] || inj_deu[p]));
	end

	// Writes land at the edge of their own cycle
	always_ff @(posedge clk) begin
		for (int p = 0; p < PORTS; p++) begin
			if (en[p] && wr[p])
				mem[addr[p]] <= wword[p];
		end
	end

	assign a_rdata = g_port[0].rdata_q;
	assign a_rdaccess = g_port[0].rdaccess_q;
	assign a_seu = g_port[0].seu_q;
	assign a_deu = g_port[0].deu_q;

	assign b_rdata = g_port[1].rdata_q;
	assign b_rdaccess = g_port[1].rdaccess_q;
	assign b_seu = g_port[1].seu_q;
	assign b_deu = g_port[1].deu_q;

endmodule

`default_nettype wire

//--- hw/uram_ctrl_pkg.sv
`default_nettype none

package uram_ctrl_pkg;

	// Issuer of a port A access
	typedef enum logic {
		OWNER_HOST	= 1'b0,
		OWNER_SCRUB	= 1'b1
	} uram_owner_e;

	// Outcome of one decoded read
	typedef enum logic [1:0] {
		ECC_CLEAN		= 2'd0,
		ECC_CORRECTED	= 2'd1,
		ECC_FATAL		= 2'd2
	} uram_ecc_status_e;

endpackage

`default_nettype wire

//--- hw/uram_defines.svh
`ifndef URAM_DEFINES_SVH
`define URAM_DEFINES_SVH

// Array geometry
`define URAM_DEPTH			64
`define URAM_ADDR_W			6

// ECC word split
`define URAM_DATA_W			64
`define URAM_CHECK_W		8
`define URAM_WORD_W			72

// Raw byte lanes of one word
`define URAM_LANES			9

// Words 0 up to this count form the ECC region
`define URAM_SCRUB_WORDS	32

`endif

//--- hw/uram_port_arbiter.sv
`default_nettype none
`include "uram_defines.svh"

module uram_port_arbiter(
	input wire									clk,
	input wire									rst_n,

	// Host request
	input wire									a_en,
	input wire									a_wr,
	input wire [`URAM_ADDR_W-1:0]				a_addr,
	input wire [`URAM_DATA_W-1:0]				a_wdata,
	input wire									a_inject_seu,
	input wire									a_inject_deu,

	// Host return
	output logic [`URAM_DATA_W-1:0]			a_rdata,
	output logic								a_rdaccess,
	output logic								a_seu,
	output logic								a_deu,

	// Scrubber request
	input wire									scrub_req,
	input wire									scrub_wr,
	input wire [`URAM_ADDR_W-1:0]				scrub_addr,
	input wire [`URAM_DATA_W-1:0]				scrub_wdata,
	output logic								scrub_gnt,

	// Scrubber return
	output logic								scrub_rdaccess,
	output logic [`URAM_DATA_W-1:0]			scrub_rdata,
	output uram_ctrl_pkg::uram_ecc_status_e		scrub_status,

	// Memory port A
	output logic								m_en,
	output logic								m_wr,
	output logic [`URAM_ADDR_W-1:0]			m_addr,
	output uram_word_pkg::uram_word_u			m_wdata,
	output logic								m_inject_seu,
	output logic								m_inject_deu,
	input wire uram_word_pkg::uram_word_u		m_rdata,
	input wire									m_rdaccess,
	input wire									m_seu,
	input wire									m_deu
);
	import uram_ctrl_pkg::*;

	// Owner of the read returning next cycle
	uram_owner_e	rd_owner;

	// Host wins whenever it strobes
	assign scrub_gnt = scrub_req && !a_en;

	assign m_en = a_en || scrub_req;
	assign m_wr = a_en ? a_wr : scrub_wr;
	assign m_addr = a_en ? a_addr : scrub_addr;

	// Check bits come from the encoder in the block
	always_comb begin
		m_wdata = '0;
		m_wdata.ecc.data = a_en ? a_wdata : scrub_wdata;
	end

	// Scrubber never injects
	assign m_inject_seu = a_en && a_inject_seu;
	assign m_inject_deu = a_en && a_inject_deu;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_owner <= OWNER_HOST;
		else if (m_en && !m_wr)
			rd_owner <= a_en ? OWNER_HOST : OWNER_SCRUB;
	end

	// Host return
	assign a_rdaccess = m_rdaccess && (rd_owner == OWNER_HOST);
	assign a_rdata = m_rdata.ecc.data;
	assign a_seu = a_rdaccess && m_seu;
	assign a_deu = a_rdaccess && m_deu;

	// Scrubber return, flags folded into one status
	assign scrub_rdaccess = m_rdaccess && (rd_owner == OWNER_SCRUB);
	assign scrub_rdata = m_rdata.ecc.data;
	always_comb begin
		if (m_deu)
			scrub_status = ECC_FATAL;
		else if (m_seu)
			scrub_status = ECC_CORRECTED;
		else
			scrub_status = ECC_CLEAN;
	end

	// Host strobes are never stalled
	host_priority_chk: assert property (@(posedge clk) disable iff (!rst_n)
		a_en && !a_wr |=> a_rdaccess);

endmodule

`default_nettype wire

//--- hw/uram_scrubber.sv
`default_nettype none
`include "uram_defines.svh"

module uram_scrubber(
	input wire									clk,
	input wire									rst_n,
	input wire									scrub_en,

	// Request to the arbiter
	output logic								scrub_req,
	output logic								scrub_wr,
	output logic [`URAM_ADDR_W-1:0]			scrub_addr,
	output logic [`URAM_DATA_W-1:0]			scrub_wdata,
	input wire									scrub_gnt,

	// Read return
	input wire									scrub_rdaccess,
	input wire [`URAM_DATA_W-1:0]				scrub_rdata,
	input wire uram_ctrl_pkg::uram_ecc_status_e	scrub_status,

	// Results
	output logic [15:0]							scrub_fixed,
	output logic [15:0]							scrub_fatal,
	output logic								scrub_pass
);
	import uram_ctrl_pkg::*;

	// FSM states
	localparam logic [1:0] ST_READ = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_WB = 2'd2;

	localparam logic [`URAM_ADDR_W-1:0] LAST_ADDR = `URAM_ADDR_W'(`URAM_SCRUB_WORDS - 1);

	logic [1:0]	state;
	logic		fixed_hit;
	logic		fatal_hit;
	logic		advance;

	// New reads only while enabled, write-back always finishes
	assign scrub_req = (state == ST_READ && scrub_en) || state == ST_WB;
	assign scrub_wr = state == ST_WB;

	// Current word done
	assign fixed_hit = state == ST_WB && scrub_gnt;
	assign fatal_hit = state == ST_WAIT && scrub_rdaccess && scrub_status == ECC_FATAL;
	assign advance = fixed_hit ||
		(state == ST_WAIT && scrub_rdaccess && scrub_status != ECC_CORRECTED);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_READ;
			scrub_addr <= '0;
			scrub_fixed <= '0;
			scrub_fatal <= '0;
			scrub_pass <= 1'b0;
		end else begin
			case (state)
				ST_READ: begin
					if (scrub_gnt)
						state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (scrub_rdaccess)
						state <= (scrub_status == ECC_CORRECTED) ? ST_WB : ST_READ;
				end
				ST_WB: begin
					if (scrub_gnt)
						state <= ST_READ;
				end
				default: state <= ST_READ;
			endcase

			// Wrap to the start of the region
			if (advance)
				scrub_addr <= (scrub_addr == LAST_ADDR) ? '0 : scrub_addr + 1'b1;
			scrub_pass <= advance && scrub_addr == LAST_ADDR;

			// Saturating error counts
			if (fixed_hit && scrub_fixed != '1)
				scrub_fixed <= scrub_fixed + 1'b1;
			if (fatal_hit && scrub_fatal != '1)
				scrub_fatal <= scrub_fatal + 1'b1;
		end
	end

	// Corrected word kept for write-back
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && scrub_rdaccess)
			scrub_wdata <= scrub_rdata;
	end

	// Raw region stays untouched
	scrub_region_chk: assert property (@(posedge clk) disable iff (!rst_n)
		scrub_req |-> scrub_addr <= LAST_ADDR);

endmodule

`default_nettype wire

//--- hw/uram_secded.sv
`default_nettype none
`include "uram_defines.svh"

module uram_secded(
	input wire [`URAM_DATA_W-1:0]				enc_data,
	output logic [`URAM_CHECK_W-1:0]			enc_check,
	input wire uram_word_pkg::uram_word_u		dec_word,
	output logic [`URAM_DATA_W-1:0]			dec_data,
	output uram_ctrl_pkg::uram_ecc_status_e		dec_status
);
	import uram_ctrl_pkg::*;

	// Hamming bits, the overall parity bit sits above them
	localparam int HAM_W = `URAM_CHECK_W - 1;
	// Highest codeword position, parity bits live at powers of two
	localparam int CODE_LAST = `URAM_DATA_W + HAM_W;

	logic [HAM_W-1:0]	enc_ham;
	logic [HAM_W-1:0]	syndrome;
	logic				parity_err;

	// XOR of the codeword positions of all set data bits
	function automatic logic [HAM_W-1:0] hamming(input logic [`URAM_DATA_W-1:0] data);
		logic [HAM_W-1:0]	syn;
		int unsigned		pos;
		int unsigned		idx;
		syn = '0;
		idx = 0;
		for (pos = 1; pos <= CODE_LAST; pos++) begin
			// Parity positions carry no data
			if ((pos & (pos - 1)) != 0) begin
				if (data[idx])
					syn = syn ^ HAM_W'(pos);
				idx++;
			end
		end
		return syn;
	endfunction

	// Encoder
	assign enc_ham = hamming(enc_data);
	// Overall parity makes the stored word even
	assign enc_check = {^{enc_ham, enc_data}, enc_ham};

	// Decoder
	assign syndrome = hamming(dec_word.ecc.data) ^ dec_word.ecc.check[HAM_W-1:0];
	assign parity_err = ^dec_word;

	always_comb begin
		int unsigned	pos;
		int unsigned	idx;
		dec_data = dec_word.ecc.data;
		idx = 0;
		for (pos = 1; pos <= CODE_LAST; pos++) begin
			if ((pos & (pos - 1)) != 0) begin
				// Flip the data bit the syndrome points at
				if (parity_err && pos == 32'(syndrome))
					dec_data[idx] = ~dec_data[idx];
				idx++;
			end
		end
	end

	// Odd parity with an in-range syndrome is a single flip
	// Even parity with a nonzero syndrome is a double flip
	always_comb begin
		if (!parity_err && syndrome == '0)
			dec_status = ECC_CLEAN;
		else if (parity_err && 32'(syndrome) <= CODE_LAST)
			dec_status = ECC_CORRECTED;
		else
			dec_status = ECC_FATAL;
	end

endmodule

`default_nettype wire

//--- hw/uram_subsystem_top.sv
`default_nettype none
`include "uram_defines.svh"

module uram_subsystem_top(
	input wire							clk,
	input wire							rst_n,

	// Host on port A
	input wire							a_en,
	input wire							a_wr,
	input wire [`URAM_ADDR_W-1:0]		a_addr,
	input wire [`URAM_DATA_W-1:0]		a_wdata,
	input wire							a_inject_seu,
	input wire							a_inject_deu,
	output logic [`URAM_DATA_W-1:0]	a_rdata,
	output logic						a_rdaccess,
	output logic						a_seu,
	output logic						a_deu,

	// Raw port B
	input wire							b_en,
	input wire							b_wr,
	input wire [`URAM_LANES-1:0]		b_bwe,
	input wire [`URAM_ADDR_W-1:0]		b_addr,
	input wire [`URAM_WORD_W-1:0]		b_wdata,
	output logic [`URAM_WORD_W-1:0]	b_rdata,
	output logic						b_rdaccess,

	// Scrubber
	input wire							scrub_en,
	output logic [15:0]					scrub_fixed,
	output logic [15:0]					scrub_fatal,
	output logic						scrub_pass
);
	import uram_word_pkg::*;
	import uram_ctrl_pkg::*;

	// Arbiter to memory port A
	logic						m_en;
	logic						m_wr;
	logic [`URAM_ADDR_W-1:0]	m_addr;
	uram_word_u					m_wdata;
	logic						m_inject_seu;
	logic						m_inject_deu;
	uram_word_u					m_rdata;
	logic						m_rdaccess;
	logic						m_seu;
	logic						m_deu;

	// Scrubber to arbiter
	logic						scrub_req;
	logic						scrub_wr;
	logic [`URAM_ADDR_W-1:0]	scrub_addr;
	logic [`URAM_DATA_W-1:0]	scrub_wdata;
	logic						scrub_gnt;
	logic						scrub_rdaccess;
	logic [`URAM_DATA_W-1:0]	scrub_rdata;
	uram_ecc_status_e			scrub_status;

	uram_port_arbiter u_arbiter(.*);

	uram_scrubber u_scrubber(.*);

	// ECC on the shared port, raw bytes on port B
	uram_block #(
		.ECC_A(1'b1),
		.ECC_B(1'b0)
	) u_block (
		.clk(clk),
		.rst_n(rst_n),
		.a_en(m_en),
		.a_wr(m_wr),
		.a_addr(m_addr),
		.a_bwe({`URAM_LANES{1'b1}}),
		.a_wdata(m_wdata),
		.a_inject_seu(m_inject_seu),
		.a_inject_deu(m_inject_deu),
		.a_rdata(m_rdata),
		.a_rdaccess(m_rdaccess),
		.a_seu(m_seu),
		.a_deu(m_deu),
		.b_en(b_en),
		.b_wr(b_wr),
		.b_addr(b_addr),
		.b_bwe(b_bwe),
		.b_wdata(b_wdata),
		.b_inject_seu(1'b0),
		.b_inject_deu(1'b0),
		.b_rdata(b_rdata),
		.b_rdaccess(b_rdaccess),
		.b_seu(),
		.b_deu()
	);

endmodule

`default_nettype wire

//--- hw/uram_word_pkg.sv
`default_nettype none
`include "uram_defines.svh"

package uram_word_pkg;

	// One stored word
	// Raw port B sees nine byte lanes
	// SECDED logic sees check bits above the payload
	typedef union packed {
		logic [`URAM_LANES-1:0][7:0]	lanes;
		struct packed {
			// Overall parity in the top bit, Hamming bits below
			logic [`URAM_CHECK_W-1:0]	check;
			logic [`URAM_DATA_W-1:0]	data;
		} ecc;
	} uram_word_u;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and judge the log
cd "$(dirname "$0")" || exit 1

top=tb_uram_subsystem
log=sim.log

verilator --binary --timing --assert -f flist.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
	echo "Result: PASS"
	exit 0
else
	echo "Result: FAIL"
	exit 1
fi

//--- sim/tb_uram_subsystem.sv
`default_nettype none
`include "uram_defines.svh"

module tb_uram_subsystem;

	localparam int CLK_PERIOD = 4;
	localparam int CHK_W = `URAM_WORD_W;

	// Row operations and ports
	localparam logic [1:0] OP_IDLE = 2'd0;
	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_READ = 2'd2;
	localparam logic PORT_A = 1'b0;
	localparam logic PORT_B = 1'b1;

	// Shadow state of one ECC word
	localparam logic [1:0] ERR_NONE = 2'd0;
	localparam logic [1:0] ERR_SINGLE = 2'd1;
	localparam logic [1:0] ERR_DOUBLE = 2'd2;

	typedef struct packed {
		logic [1:0]					op;
		logic						port;
		logic [`URAM_ADDR_W-1:0]	addr;
		logic [`URAM_WORD_W-1:0]	wdata;
		logic [`URAM_LANES-1:0]		bwe;
		logic						inj_seu;
		logic						inj_deu;
		logic [`URAM_WORD_W-1:0]	exp_data;
		logic						exp_seu;
		logic						exp_deu;
		// Data of a double error is not compared
		logic						chk_data;
	} row_t;

	logic						clk;
	logic						rst_n;
	logic						a_en;
	logic						a_wr;
	logic [`URAM_ADDR_W-1:0]	a_addr;
	logic [`URAM_DATA_W-1:0]	a_wdata;
	logic						a_inject_seu;
	logic						a_inject_deu;
	logic [`URAM_DATA_W-1:0]	a_rdata;
	logic						a_rdaccess;
	logic						a_seu;
	logic						a_deu;
	logic						b_en;
	logic						b_wr;
	logic [`URAM_LANES-1:0]		b_bwe;
	logic [`URAM_ADDR_W-1:0]	b_addr;
	logic [`URAM_WORD_W-1:0]	b_wdata;
	logic [`URAM_WORD_W-1:0]	b_rdata;
	logic						b_rdaccess;
	logic						scrub_en;
	logic [15:0]				scrub_fixed;
	logic [15:0]				scrub_fatal;
	logic						scrub_pass;

	// Stimulus table and its names
	row_t						rows [$];
	string						names [$];

	// Shadow models of both regions
	logic [`URAM_DATA_W-1:0]	ecc_data [`URAM_SCRUB_WORDS];
	logic [1:0]					ecc_err [`URAM_SCRUB_WORDS];
	logic [`URAM_WORD_W-1:0]	raw_shadow [`URAM_DEPTH];

	logic						rows_ready;
	int							wd_cycles;

	uram_subsystem_top uut(.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
			input logic [CHK_W-1:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic push_a_write(input string name, input int addr,
			input logic [`URAM_DATA_W-1:0] data, input logic seu, input logic deu);
		row_t r;
		r = '0;
		r.op = OP_WRITE;
		r.port = PORT_A;
		r.addr = `URAM_ADDR_W'(addr);
		r.wdata = CHK_W'(data);
		r.inj_seu = seu;
		r.inj_deu = deu;
		ecc_data[addr] = data;
		ecc_err[addr] = deu ? ERR_DOUBLE : (seu ? ERR_SINGLE : ERR_NONE);
		rows.push_back(r);
		names.push_back($sformatf("%s_%0d", name, addr));
	endtask

	// Expected read follows the shadow word and its error state
	task automatic push_a_read(input string name, input int addr);
		row_t r;
		r = '0;
		r.op = OP_READ;
		r.port = PORT_A;
		r.addr = `URAM_ADDR_W'(addr);
		r.exp_data = CHK_W'(ecc_data[addr]);
		r.exp_seu = ecc_err[addr] == ERR_SINGLE;
		r.exp_deu = ecc_err[addr] == ERR_DOUBLE;
		r.chk_data = ecc_err[addr] != ERR_DOUBLE;
		rows.push_back(r);
		names.push_back($sformatf("%s_%0d", name, addr));
	endtask

	task automatic push_b_write(input string name, input int addr,
			input logic [`URAM_WORD_W-1:0] data, input logic [`URAM_LANES-1:0] bwe);
		row_t r;
		r = '0;
		r.op = OP_WRITE;
		r.port = PORT_B;
		r.addr = `URAM_ADDR_W'(addr);
		r.wdata = data;
		r.bwe = bwe;
		// Only enabled lanes change
		for (int l = 0; l < `URAM_LANES; l++) begin
			if (bwe[l])
				raw_shadow[addr][l*8 +: 8] = data[l*8 +: 8];
		end
		rows.push_back(r);
		names.push_back($sformatf("%s_%0d", name, addr));
	endtask

	task automatic push_b_read(input string name, input int addr);
		row_t r;
		r = '0;
		r.op = OP_READ;
		r.port = PORT_B;
		r.addr = `URAM_ADDR_W'(addr);
		r.exp_data = raw_shadow[addr];
		r.chk_data = 1'b1;
		rows.push_back(r);
		names.push_back($sformatf("%s_%0d", name, addr));
	endtask

	task automatic drive_idle();
		a_en = 1'b0;
		a_wr = 1'b0;
		a_inject_seu = 1'b0;
		a_inject_deu = 1'b0;
		b_en = 1'b0;
		b_wr = 1'b0;
	endtask

	task automatic drive_row(input int idx);
		row_t r;
		r = rows[idx];
		a_en = r.op != OP_IDLE && r.port == PORT_A;
		a_wr = r.op == OP_WRITE;
		a_addr = r.addr;
		a_wdata = r.wdata[`URAM_DATA_W-1:0];
		a_inject_seu = r.inj_seu;
		a_inject_deu = r.inj_deu;
		b_en = r.op != OP_IDLE && r.port == PORT_B;
		b_wr = r.op == OP_WRITE;
		b_addr = r.addr;
		b_wdata = r.wdata;
		b_bwe = r.bwe;
	endtask

	// Return of the row strobed one cycle earlier, idx below zero for none
	task automatic check_return(input int idx);
		row_t r;
		string n;
		logic a_exp;
		logic b_exp;
		r = '0;
		n = "idle";
		a_exp = 1'b0;
		b_exp = 1'b0;
		if (idx >= 0) begin
			r = rows[idx];
			n = names[idx];
			a_exp = r.op == OP_READ && r.port == PORT_A;
			b_exp = r.op == OP_READ && r.port == PORT_B;
		end
		check_value({n, "_a_rdaccess"}, CHK_W'(a_exp), CHK_W'(a_rdaccess));
		check_value({n, "_b_rdaccess"}, CHK_W'(b_exp), CHK_W'(b_rdaccess));
		if (a_exp) begin
			if (r.chk_data)
				check_value({n, "_data"}, r.exp_data, CHK_W'(a_rdata));
			check_value({n, "_seu"}, CHK_W'(r.exp_seu), CHK_W'(a_seu));
			check_value({n, "_deu"}, CHK_W'(r.exp_deu), CHK_W'(a_deu));
		end
		if (b_exp)
			check_value({n, "_data"}, r.exp_data, b_rdata);
	endtask

	// Rows first up to last, excluding last, one per cycle
	task automatic run_rows(input int first, input int last);
		int pending;
		pending = -1;
		for (int i = first; i < last; i++) begin
			@(negedge clk);
			check_return(pending);
			drive_row(i);
			pending = i;
		end
		@(negedge clk);
		check_return(pending);
		drive_idle();
	endtask

	task automatic wait_scrub_pass();
		@(negedge clk);
		while (!scrub_pass)
			@(negedge clk);
	endtask

	// Table length plus two scrub passes, doubled
	initial begin
		wait (rows_ready);
		#(wd_cycles * CLK_PERIOD);
		$display("Watchdog expired before all reads and scrub passes completed");
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

	initial begin
		int k;
		int m;
		int seg1_end;
		int seg2_end;
		int seg3_end;
		rows_ready = 1'b0;
		wd_cycles = 0;
		rst_n = 1'b0;
		a_addr = '0;
		a_wdata = '0;
		b_addr = '0;
		b_wdata = '0;
		b_bwe = '0;
		scrub_en = 1'b0;
		drive_idle();
		void'($urandom(92900));

		// Memory starts all zero
		for (int a = 0; a < `URAM_SCRUB_WORDS; a++) begin
			ecc_data[a] = '0;
			ecc_err[a] = ERR_NONE;
		end
		for (int a = 0; a < `URAM_DEPTH; a++)
			raw_shadow[a] = '0;

		// ECC writes then back-to-back reads
		for (int a = 0; a < 8; a++)
			push_a_write("ecc_wr", a, {$urandom(), $urandom()}, 1'b0, 1'b0);
		for (int a = 0; a < 8; a++)
			push_a_read("ecc_rd", a);
		// Read right after a write of the same word
		push_a_write("ecc_wr", 20, {$urandom(), $urandom()}, 1'b0, 1'b0);
		push_a_read("ecc_rd_after_wr", 20);
		push_a_read("ecc_rd_blank", 25);

		// Injected errors, singles on 8 10 12, doubles on 9 13
		push_a_write("inj_seu", 8, {$urandom(), $urandom()}, 1'b1, 1'b0);
		push_a_write("inj_deu", 9, {$urandom(), $urandom()}, 1'b0, 1'b1);
		push_a_write("inj_seu", 10, {$urandom(), $urandom()}, 1'b1, 1'b0);
		push_a_write("ecc_wr", 11, {$urandom(), $urandom()}, 1'b0, 1'b0);
		push_a_write("inj_seu", 12, {$urandom(), $urandom()}, 1'b1, 1'b0);
		push_a_write("inj_deu", 13, {$urandom(), $urandom()}, 1'b0, 1'b1);
		for (int a = 8; a < 14; a++)
			push_a_read("inj_rd", a);

		// Raw region, full words then partial lanes
		for (int a = 32; a < 40; a++)
			push_b_write("raw_full", a, {8'($urandom()), $urandom(), $urandom()}, '1);
		for (int a = 32; a < 40; a++)
			push_b_write("raw_part", a, {8'($urandom()), $urandom(), $urandom()},
				`URAM_LANES'($urandom()));
		for (int a = 32; a < 40; a++)
			push_b_read("raw_rd", a);
		push_b_read("raw_rd_blank", 50);
		seg1_end = rows.size();

		// Expected counts, then the scrubbed state of the region
		k = 0;
		m = 0;
		for (int a = 0; a < `URAM_SCRUB_WORDS; a++) begin
			if (ecc_err[a] == ERR_SINGLE) begin
				k++;
				ecc_err[a] = ERR_NONE;
			end else if (ecc_err[a] == ERR_DOUBLE) begin
				m++;
			end
		end

		for (int a = 8; a < 14; a++)
			push_a_read("scrubbed_rd", a);
		seg2_end = rows.size();
		// Host read every cycle over the whole region
		for (int a = 0; a < `URAM_SCRUB_WORDS; a++)
			push_a_read("burst_rd", a);
		seg3_end = rows.size();

		wd_cycles = 2 * (seg3_end + 10 + 2 * 4 * `URAM_SCRUB_WORDS);
		rows_ready = 1'b1;

		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("reset_fixed", '0, CHK_W'(scrub_fixed));
		check_value("reset_fatal", '0, CHK_W'(scrub_fatal));
		check_value("reset_pass", '0, CHK_W'(scrub_pass));

		run_rows(0, seg1_end);

		// First pass with the host idle
		scrub_en = 1'b1;
		wait_scrub_pass();
		check_value("pass1_fixed", CHK_W'(k), CHK_W'(scrub_fixed));
		check_value("pass1_fatal", CHK_W'(m), CHK_W'(scrub_fatal));
		scrub_en = 1'b0;
		run_rows(seg1_end, seg2_end);

		// Scrubber competes with a host read burst
		scrub_en = 1'b1;
		run_rows(seg2_end, seg3_end);
		wait_scrub_pass();
		// Doubles stay uncorrectable and count again
		check_value("pass2_fixed", CHK_W'(k), CHK_W'(scrub_fixed));
		check_value("pass2_fatal", CHK_W'(2 * m), CHK_W'(scrub_fatal));

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
